// ==== hdl/com_pkg.sv ====
package com_pkg;

    // ----------------------------------------
    // Host link word types
    // ----------------------------------------
    typedef enum logic [1:0] {
        TLP  = 2'b00,                     // PCIe TLP beat
        CFG  = 2'b01,                     // Config access, not handled here
        LOOP = 2'b10,                     // Echoed back to host
        CMD  = 2'b11                      // Register file access
    } link_type_e;

    localparam logic [7:0] LINK_MAGIC = 8'h77;   // Marks a well-formed link word

    // Flag nibble, bits 15:12 of the link word
    typedef struct packed {
        logic [1:0] rsvd;                 // Reserved
        logic       write;                // Command write request
        logic       read;                 // Command read request
    } link_flags_t;

    // 64-bit link word, same layout in both directions
    typedef struct packed {
        logic [31:0] payload;             // 63:32
        logic [15:0] addr;                // 31:16, byte address for commands
        link_flags_t flags;               // 15:12
        logic [1:0]  ctx;                 // 11:10, {first, last} on TLP words
        link_type_e  ltype;               // 9:8
        logic [7:0]  magic;               // 7:0
    } link_word_t;

    // One 32-bit beat to or from the PCIe core
    typedef struct packed {
        logic [31:0] data;
        logic        first;
        logic        last;
    } tlp_beat_t;

    // Item waiting for the host-side merge
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  ctx;
        link_type_e  tag;                 // Becomes the type field on output
    } tx_item_t;

endpackage

// ==== hdl/ctl_pkg.sv ====
package ctl_pkg;

    // ----------------------------------------
    // Command decode
    // ----------------------------------------
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } cmd_op_e;

    // Decoded command, mask and value in bit order
    typedef struct packed {
        cmd_op_e     op;
        logic [15:0] addr;                // Byte address, bit 15 picks the rw bank
        logic [15:0] mask;                // Bit i enables write of value bit i
        logic [15:0] value;
    } ctl_cmd_t;

    // ----------------------------------------
    // Register banks
    // ----------------------------------------
    localparam int RO_BITS  = 128;
    localparam int RW_BITS  = 128;
    localparam int RO_BYTES = RO_BITS / 8;       // Reported at ro +4
    localparam int RW_BYTES = RW_BITS / 8;       // Reset value of rw +4

    localparam logic [15:0] RO_MAGIC = 16'hab89; // ro +0
    localparam logic [15:0] RW_MAGIC = 16'hefcd; // rw +0

    // Control bits at rw +2
    localparam int RWPOS_SEND_EN = 17;           // Start the send-count stream

    // Send-count word, shares rw +4 with the byte count
    localparam int RWPOS_SEND_CNT = 32;
    localparam int SEND_CNT_BITS  = 16;

    // Address echoed on every send-count item
    localparam logic [15:0] SEND_ADDR = 16'hfffe;

    // Address bit that selects the rw bank
    localparam int ADDR_RW_BIT = 15;

    // Register access width
    localparam int REG_BITS = 16;

endpackage

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16                  // Power of two, at least 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_wr_en,
    input  logic [WIDTH-1:0] i_din,
    input  logic             i_rd_en,
    output logic [WIDTH-1:0] o_dout,
    output logic             o_valid,
    output logic             o_afull
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;                  // Occupied entries
    logic             do_wr;
    logic             do_rd;

    assign do_wr = i_wr_en && (count != (AW+1)'(DEPTH));   // Lost when full
    assign do_rd = i_rd_en && o_valid;

    // Head word falls through
    assign o_dout  = mem[rd_ptr];
    assign o_valid = (count != '0);
    assign o_afull = (count >= (AW+1)'(DEPTH - 2));        // Two or fewer free

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;            // Wraps at DEPTH
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

endmodule

// ==== hdl/rx_router.sv ====
`timescale 1ns/1ns

module rx_router (
    input  logic                clk,
    input  logic                rst,
    input  com_pkg::link_word_t i_host_word,
    input  logic                i_host_valid,
    output com_pkg::tlp_beat_t  o_tlp_tx,
    output logic                o_tlp_tx_valid,
    output com_pkg::tx_item_t   o_loop_item,
    output logic                o_loop_wr,
    output ctl_pkg::ctl_cmd_t   o_cmd,
    output logic                o_cmd_wr
);

    import com_pkg::*;
    import ctl_pkg::*;

    logic word_ok;                            // Valid strobe with good magic
    logic cmd_rd;
    logic cmd_wr_ok;                          // Write flag and rw bank addressed

    assign word_ok   = i_host_valid && (i_host_word.magic == LINK_MAGIC);
    assign cmd_rd    = i_host_word.flags.read;
    assign cmd_wr_ok = i_host_word.flags.write && i_host_word.addr[ADDR_RW_BIT];

    // One strobe per good word, CFG falls through to nothing
    always_ff @(posedge clk) begin
        if (rst) begin
            o_tlp_tx_valid <= 1'b0;
            o_loop_wr      <= 1'b0;
            o_cmd_wr       <= 1'b0;
        end else begin
            o_tlp_tx_valid <= word_ok && (i_host_word.ltype == TLP);
            o_loop_wr      <= word_ok && (i_host_word.ltype == LOOP);
            o_cmd_wr       <= word_ok && (i_host_word.ltype == CMD) && (cmd_rd || cmd_wr_ok);
        end
    end

    // Payload side, captured with every host word
    always_ff @(posedge clk) begin
        if (i_host_valid) begin
            o_tlp_tx.data  <= i_host_word.payload;
            o_tlp_tx.first <= i_host_word.ctx[1];
            o_tlp_tx.last  <= i_host_word.ctx[0];        // End of TLP
            o_loop_item    <= '{data: i_host_word.payload, ctx: i_host_word.ctx, tag: LOOP};
            o_cmd.op       <= cmd_rd ? READ : WRITE;     // Read wins over write
            o_cmd.addr     <= i_host_word.addr;
            o_cmd.mask     <= {i_host_word.payload[7:0], i_host_word.payload[15:8]};
            o_cmd.value    <= {i_host_word.payload[23:16], i_host_word.payload[31:24]};
        end
    end

endmodule

// ==== hdl/ctl_regfile.sv ====
`timescale 1ns/1ns

module ctl_regfile #(
    parameter logic [7:0]  DEVICE_ID     = 8'h00,
    parameter logic [7:0]  VERSION_MAJOR = 8'h00,
    parameter logic [7:0]  VERSION_MINOR = 8'h00,
    parameter logic [31:0] CUSTOM_VALUE  = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  ctl_pkg::ctl_cmd_t i_cmd,
    input  logic              i_cmd_valid,
    input  logic              i_resp_afull,
    output logic              o_cmd_rd_en,
    output com_pkg::tx_item_t o_resp,
    output logic              o_resp_wr
);

    import com_pkg::*;
    import ctl_pkg::*;

    localparam int RO_IW = $clog2(RO_BITS);
    localparam int RW_IW = $clog2(RW_BITS);

    logic [RO_BITS-1:0]          ro;
    logic [RW_BITS-1:0]          rw;
    logic [RO_BITS+REG_BITS-1:0] ro_pad;      // Zero tail for the last word
    logic [RW_BITS+REG_BITS-1:0] rw_pad;
    logic [ADDR_RW_BIT+2:0]      bit_off;     // Byte address times eight
    logic                        sel_rw;
    logic                        in_range;
    logic [REG_BITS-1:0]         rd_word;
    logic [SEND_CNT_BITS-1:0]    send_cnt;
    logic                        send_go;
    logic                        cmd_read;
    logic                        cmd_write;

    // ----------------------------------------
    // Read-only bank
    // ----------------------------------------
    assign ro = {
        CUSTOM_VALUE,                         // +0C
        8'h00,                                // +0B
        DEVICE_ID,                            // +0A
        VERSION_MINOR,                        // +09
        VERSION_MAJOR,                        // +08
        32'(RO_BYTES),                        // +04 byte count
        16'h0000,                             // +02
        RO_MAGIC                              // +00
    };

    assign ro_pad = {{REG_BITS{1'b0}}, ro};
    assign rw_pad = {{REG_BITS{1'b0}}, rw};

    // ----------------------------------------
    // Command decode and read path
    // ----------------------------------------
    assign o_cmd_rd_en = i_cmd_valid && !i_resp_afull;   // Room for one response
    assign cmd_read    = o_cmd_rd_en && (i_cmd.op == READ);
    assign cmd_write   = o_cmd_rd_en && (i_cmd.op == WRITE);

    assign bit_off  = {i_cmd.addr[ADDR_RW_BIT-1:0], 3'b000};
    assign sel_rw   = i_cmd.addr[ADDR_RW_BIT];
    assign in_range = sel_rw ? (int'(bit_off) < RW_BITS) : (int'(bit_off) < RO_BITS);

    always_comb begin
        rd_word = '0;                         // Beyond the bank reads zero
        if (in_range) begin
            if (sel_rw) begin
                rd_word = rw_pad[bit_off[RW_IW-1:0] +: REG_BITS];
            end else begin
                rd_word = ro_pad[bit_off[RO_IW-1:0] +: REG_BITS];
            end
        end
    end

    // Send count only fills idle command slots
    assign send_cnt = rw[RWPOS_SEND_CNT +: SEND_CNT_BITS];
    assign send_go  = !o_cmd_rd_en && rw[RWPOS_SEND_EN] && (send_cnt != '0) && !i_resp_afull;

    // ----------------------------------------
    // Response, one cycle after the pop
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            o_resp_wr <= 1'b0;
        end else begin
            o_resp_wr <= cmd_read || send_go;    // Writes stay silent
        end
    end

    always_ff @(posedge clk) begin
        if (send_go) begin
            o_resp <= '{data: {SEND_ADDR, send_cnt}, ctx: 2'b00, tag: CMD};
        end else begin
            // Value goes back byte-swapped, as the host expects
            o_resp <= '{data: {i_cmd.addr, rd_word[7:0], rd_word[15:8]}, ctx: 2'b00, tag: CMD};
        end
    end

    // ----------------------------------------
    // Read-write bank
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rw                                  <= '0;   // Control and scratch clear
            rw[15:0]                            <= RW_MAGIC;
            rw[RWPOS_SEND_CNT +: 32]            <= 32'(RW_BYTES);
        end else if (cmd_write && sel_rw) begin
            for (int i = 0; i < REG_BITS; i++) begin
                // Masked bit write, clipped at bank end
                if (i_cmd.mask[i] && (int'(bit_off) + i < RW_BITS)) begin
                    rw[int'(bit_off) + i] <= i_cmd.value[i];
                end
            end
        end else if (send_go) begin
            rw[RWPOS_SEND_CNT +: SEND_CNT_BITS] <= send_cnt - 1'b1;   // Counts down to zero
        end
    end

endmodule

// ==== hdl/tx_mux.sv ====
`timescale 1ns/1ns

module tx_mux (
    input  logic                clk,
    input  logic                rst,
    input  com_pkg::tx_item_t   i_tlp,
    input  logic                i_tlp_valid,
    output logic                o_tlp_rd_en,
    input  com_pkg::tx_item_t   i_resp,
    input  logic                i_resp_valid,
    output logic                o_resp_rd_en,
    input  com_pkg::tx_item_t   i_loop,
    input  logic                i_loop_valid,
    output logic                o_loop_rd_en,
    input  logic                i_host_ready,
    output com_pkg::link_word_t o_host_word,
    output logic                o_host_valid
);

    import com_pkg::*;

    logic     load;                           // Output register free this cycle
    logic     pick_valid;
    tx_item_t pick;

    assign load = !o_host_valid || i_host_ready;

    // Strict priority, TLP first and loopback last
    assign o_tlp_rd_en  = load && i_tlp_valid;
    assign o_resp_rd_en = load && !i_tlp_valid && i_resp_valid;
    assign o_loop_rd_en = load && !i_tlp_valid && !i_resp_valid && i_loop_valid;

    assign pick_valid = i_tlp_valid || i_resp_valid || i_loop_valid;

    always_comb begin
        if (i_tlp_valid)       pick = i_tlp;
        else if (i_resp_valid) pick = i_resp;
        else                   pick = i_loop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_host_valid <= 1'b0;
        end else if (load) begin
            o_host_valid <= pick_valid;       // Drops when nothing is waiting
        end
    end

    // Held until the host takes it
    always_ff @(posedge clk) begin
        if (load && pick_valid) begin
            o_host_word <= '{payload: pick.data, addr: 16'h0000, flags: '0,
                             ctx: pick.ctx, ltype: pick.tag, magic: LINK_MAGIC};
        end
    end

endmodule

// ==== hdl/fifo_ctl_top.sv ====
`timescale 1ns/1ns

module fifo_ctl_top #(
    parameter logic [7:0]  DEVICE_ID     = 8'h00,
    parameter logic [7:0]  VERSION_MAJOR = 8'h00,
    parameter logic [7:0]  VERSION_MINOR = 8'h00,
    parameter logic [31:0] CUSTOM_VALUE  = 32'h0000_0000,
    parameter int          FIFO_DEPTH    = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  com_pkg::link_word_t i_host_word,     // From host link
    input  logic                i_host_valid,
    input  logic                i_host_ready,
    output com_pkg::link_word_t o_host_word,     // To host link
    output logic                o_host_valid,
    output com_pkg::tlp_beat_t  o_tlp_tx,        // To PCIe core
    output logic                o_tlp_tx_valid,
    input  com_pkg::tlp_beat_t  i_tlp_rx,        // From PCIe core
    input  logic                i_tlp_rx_valid,
    output logic                o_tlp_rx_rd_en
);

    import com_pkg::*;
    import ctl_pkg::*;

    tx_item_t loop_in,  loop_out;
    logic     loop_wr,  loop_valid,  loop_rd;
    ctl_cmd_t cmd_in,   cmd_out;
    logic     cmd_wr,   cmd_valid,   cmd_rd;
    tx_item_t resp_in,  resp_out;
    logic     resp_wr,  resp_valid,  resp_rd,  resp_afull;
    tx_item_t tlp_item;

    // Core beat as a mux item, ctx is {first, last}
    assign tlp_item = '{data: i_tlp_rx.data, ctx: {i_tlp_rx.first, i_tlp_rx.last}, tag: TLP};

    // ----------------------------------------
    // Host to core and FIFOs
    // ----------------------------------------
    rx_router rx_router_i (
        .clk, .rst, .i_host_word, .i_host_valid, .o_tlp_tx, .o_tlp_tx_valid,
        .o_loop_item (loop_in), .o_loop_wr (loop_wr), .o_cmd (cmd_in), .o_cmd_wr (cmd_wr)
    );

    sync_fifo #(.WIDTH($bits(tx_item_t)), .DEPTH(FIFO_DEPTH)) loop_fifo (
        .clk, .rst, .i_wr_en (loop_wr), .i_din (loop_in), .i_rd_en (loop_rd),
        .o_dout (loop_out), .o_valid (loop_valid), .o_afull ()
    );

    sync_fifo #(.WIDTH($bits(ctl_cmd_t)), .DEPTH(FIFO_DEPTH)) cmd_fifo (
        .clk, .rst, .i_wr_en (cmd_wr), .i_din (cmd_in), .i_rd_en (cmd_rd),
        .o_dout (cmd_out), .o_valid (cmd_valid), .o_afull ()
    );

    // ----------------------------------------
    // Register file and return path
    // ----------------------------------------
    ctl_regfile #(
        .DEVICE_ID (DEVICE_ID), .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR), .CUSTOM_VALUE (CUSTOM_VALUE)
    ) ctl_regfile_i (
        .clk, .rst, .i_cmd (cmd_out), .i_cmd_valid (cmd_valid), .i_resp_afull (resp_afull),
        .o_cmd_rd_en (cmd_rd), .o_resp (resp_in), .o_resp_wr (resp_wr)
    );

    sync_fifo #(.WIDTH($bits(tx_item_t)), .DEPTH(FIFO_DEPTH)) resp_fifo (
        .clk, .rst, .i_wr_en (resp_wr), .i_din (resp_in), .i_rd_en (resp_rd),
        .o_dout (resp_out), .o_valid (resp_valid), .o_afull (resp_afull)
    );

    tx_mux tx_mux_i (
        .clk, .rst,
        .i_tlp (tlp_item), .i_tlp_valid (i_tlp_rx_valid), .o_tlp_rd_en (o_tlp_rx_rd_en),
        .i_resp (resp_out), .i_resp_valid (resp_valid), .o_resp_rd_en (resp_rd),
        .i_loop (loop_out), .i_loop_valid (loop_valid), .o_loop_rd_en (loop_rd),
        .i_host_ready, .o_host_word, .o_host_valid
    );

endmodule

// ==== tests/tb_fifo_ctl.sv ====
`timescale 1ns/1ns

module tb_fifo_ctl;

    import com_pkg::*;
    import ctl_pkg::*;

    localparam logic [7:0]  DEV_ID    = 8'h5a;
    localparam logic [7:0]  VER_MAJOR = 8'h02;
    localparam logic [7:0]  VER_MINOR = 8'h07;
    localparam logic [31:0] CUSTOM    = 32'hc0de_1234;
    localparam int          N_LOOP    = 16;
    localparam int          N_BP      = 48;
    localparam int          N_STIM    = 71 + N_BP;   // Host words plus core beats

    logic       clk;
    logic       rst;
    link_word_t i_host_word;
    logic       i_host_valid;
    logic       i_host_ready;
    link_word_t o_host_word;
    logic       o_host_valid;
    tlp_beat_t  o_tlp_tx;
    logic       o_tlp_tx_valid;
    tlp_beat_t  i_tlp_rx;
    logic       i_tlp_rx_valid;
    logic       o_tlp_rx_rd_en;

    integer       seed = 32'hcb07384f;
    logic         bp_en = 1'b0;                    // Random host stalls
    logic [127:0] rw_model;                        // Expected rw bank
    link_word_t   exp_tlp[$];
    link_word_t   exp_cmd[$];
    link_word_t   exp_loop[$];
    tlp_beat_t    core_q[$];                       // Beats the core still offers
    logic         held = 1'b0;
    link_word_t   held_word;
    logic         tx_exp_valid = 1'b0;
    tlp_beat_t    tx_exp;

    fifo_ctl_top #(
        .DEVICE_ID (DEV_ID), .VERSION_MAJOR (VER_MAJOR), .VERSION_MINOR (VER_MINOR),
        .CUSTOM_VALUE (CUSTOM), .FIFO_DEPTH (16)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic link_word_t make_word(input link_type_e t, input logic rd, input logic wr,
                                             input logic [15:0] addr, input logic [31:0] payload,
                                             input logic [1:0] ctx, input logic [7:0] magic);
        return '{payload: payload, addr: addr, flags: '{rsvd: 2'b00, write: wr, read: rd},
                 ctx: ctx, ltype: t, magic: magic};
    endfunction

    // Item as it leaves on the host link with addr and flags zero
    function automatic link_word_t expected_word(input link_type_e tag, input logic [31:0] data,
                                                 input logic [1:0] ctx);
        return make_word(tag, 1'b0, 1'b0, 16'h0000, data, ctx, LINK_MAGIC);
    endfunction

    function automatic logic [15:0] model_read(input logic [15:0] addr);
        logic [143:0] ro_pad;
        logic [143:0] rw_pad;
        int           off;
        off    = int'(addr[14:0]) * 8;
        ro_pad = {16'h0000, CUSTOM, 8'h00, DEV_ID, VER_MINOR, VER_MAJOR, 32'd16, 16'h0000, RO_MAGIC};
        rw_pad = {16'h0000, rw_model};
        if (off >= 128) return 16'h0000;           // Past either bank
        return addr[15] ? rw_pad[8'(off) +: 16] : ro_pad[8'(off) +: 16];
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [15:0] mask,
                               input logic [15:0] value);
        int          off;
        logic [15:0] cnt;
        off = int'(addr[14:0]) * 8;
        for (int i = 0; i < 16; i++) begin
            if (mask[i] && off + i < RW_BITS) rw_model[7'(off + i)] = value[i];
        end
        // Enabled count streams down to one
        cnt = rw_model[RWPOS_SEND_CNT +: 16];
        while (rw_model[RWPOS_SEND_EN] && cnt != 16'h0000) begin
            exp_cmd.push_back(expected_word(CMD, {SEND_ADDR, cnt}, 2'b00));
            cnt = cnt - 16'd1;
        end
        rw_model[RWPOS_SEND_CNT +: 16] = cnt;
    endtask

    function automatic int pending();
        return exp_tlp.size() + exp_cmd.size() + exp_loop.size();
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // ----------------------------------------
    // Host side stimulus
    // ----------------------------------------
    task automatic send_word(input link_word_t w);
        while (pending() > 8) @(posedge clk);     // Keep FIFOs from overflowing
        @(posedge clk);
        #2;
        i_host_word  = w;
        i_host_valid = 1'b1;
        @(posedge clk);
        #2;
        i_host_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr);
        logic [15:0] v;
        v = model_read(addr);
        exp_cmd.push_back(expected_word(CMD, {addr, v[7:0], v[15:8]}, 2'b00));
        send_word(make_word(CMD, 1'b1, 1'b0, addr, 32'h0, 2'b00, LINK_MAGIC));
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] mask,
                             input logic [15:0] value);
        if (addr[15]) model_write(addr, mask, value);   // Router drops the rest
        send_word(make_word(CMD, 1'b0, 1'b1, addr,
                            {value[7:0], value[15:8], mask[7:0], mask[15:8]}, 2'b00, LINK_MAGIC));
    endtask

    task automatic send_loop(input logic [31:0] data, input logic [1:0] ctx);
        exp_loop.push_back(expected_word(LOOP, data, ctx));
        send_word(make_word(LOOP, 1'b0, 1'b0, 16'h0000, data, ctx, LINK_MAGIC));
    endtask

    // Core beats join the queue at the falling edge
    task automatic queue_core_beat(input logic [31:0] data, input logic first, input logic last);
        @(negedge clk);
        core_q.push_back('{data: data, first: first, last: last});
        exp_tlp.push_back(expected_word(TLP, data, {first, last}));
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        while (pending() != 0) @(posedge clk);
        repeat (4) @(posedge clk);                // Catch stray words
    endtask

    // ----------------------------------------
    // Checking
    // ----------------------------------------
    task automatic check_host(input link_word_t got);
        link_word_t exp;
        int         avail;
        case (got.ltype)
            TLP:     avail = exp_tlp.size();
            CMD:     avail = exp_cmd.size();
            LOOP:    avail = exp_loop.size();
            default: avail = 0;
        endcase
        assert (avail != 0)
            else report_fail($sformatf("Host word %h arrived with nothing expected", got));
        case (got.ltype)
            TLP:     exp = exp_tlp.pop_front();
            CMD:     exp = exp_cmd.pop_front();
            default: exp = exp_loop.pop_front();
        endcase
        assert (got == exp)
            else report_fail($sformatf("CHECK FAILED t=%0t o_host_word exp=%h got=%h",
                                       $time, exp, got));
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (held) begin
                assert (o_host_valid && o_host_word == held_word)
                    else report_fail($sformatf("CHECK FAILED t=%0t o_host_word exp=%h got=%h",
                                               $time, held_word, o_host_word));
            end
            if (o_host_valid && i_host_ready) check_host(o_host_word);   // Taken at next edge
            assert (o_tlp_tx_valid == tx_exp_valid)
                else report_fail($sformatf("CHECK FAILED t=%0t o_tlp_tx_valid exp=%b got=%b",
                                           $time, tx_exp_valid, o_tlp_tx_valid));
            if (tx_exp_valid) begin
                assert (o_tlp_tx == tx_exp)
                    else report_fail($sformatf("CHECK FAILED t=%0t o_tlp_tx exp=%h got=%h",
                                               $time, tx_exp, o_tlp_tx));
            end
        end
        held         = o_host_valid && !i_host_ready;
        held_word    = o_host_word;
        // Good TLP word now means a beat one cycle on
        tx_exp_valid = i_host_valid && i_host_word.magic == LINK_MAGIC && i_host_word.ltype == TLP;
        tx_exp       = '{data: i_host_word.payload, first: i_host_word.ctx[1],
                         last: i_host_word.ctx[0]};
    end

    // PCIe core model as an FWFT source
    initial begin
        logic popped;
        i_tlp_rx       = '0;
        i_tlp_rx_valid = 1'b0;
        forever begin
            @(negedge clk);
            popped = i_tlp_rx_valid && o_tlp_rx_rd_en;
            @(posedge clk);
            #2;
            if (popped) void'(core_q.pop_front());
            i_tlp_rx_valid = (core_q.size() != 0);
            if (core_q.size() != 0) i_tlp_rx = core_q[0];
        end
    end

    // Host ready with random stalls when enabled
    initial begin
        logic [31:0] rnd;
        logic        next_ready;
        i_host_ready = 1'b1;
        forever begin
            @(negedge clk);
            rnd        = $random(seed);
            next_ready = !bp_en || rnd[0];
            @(posedge clk);
            #2;
            i_host_ready = next_ready;
        end
    end

    initial begin
        repeat (200 * N_STIM) @(posedge clk);
        report_fail($sformatf("Watchdog timeout after %0d cycles, streams stalled", 200 * N_STIM));
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        rst          = 1'b1;
        i_host_word  = '0;
        i_host_valid = 1'b0;
        rw_model                       = '0;
        rw_model[15:0]                 = RW_MAGIC;
        rw_model[RWPOS_SEND_CNT +: 32] = 32'd16;   // rw byte count
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        assert (!o_host_valid && !o_tlp_tx_valid && !o_tlp_rx_rd_en)
            else report_fail($sformatf("CHECK FAILED t=%0t valid outputs exp=000 got=%b%b%b",
                                       $time, o_host_valid, o_tlp_tx_valid, o_tlp_rx_rd_en));
        for (int a = 0; a < 16; a += 2) read_reg(16'(a));          // Whole ro bank
        read_reg(16'h0020);
        wait_drain();

        for (int a = 0; a < 16; a += 2) read_reg(16'h8000 + 16'(a));   // rw defaults
        write_reg(16'h8008, 16'hffff, 16'h1234);
        write_reg(16'h800a, 16'h00ff, 16'habcd);
        write_reg(16'h800c, 16'hf0f0, 16'h5a5a);
        write_reg(16'h800f, 16'hffff, 16'h9876);   // Upper byte falls off the bank
        write_reg(16'h0008, 16'hffff, 16'hdead);   // rw bit clear
        for (int a = 8; a <= 16; a += 2) read_reg(16'h8000 + 16'(a));
        wait_drain();

        // Loopback mixed with bad magic and CFG words
        for (int i = 0; i < N_LOOP; i++) begin
            r = $random(seed);
            d = $random(seed);
            send_loop(d, r[1:0]);
            if (i % 4 == 3) begin
                send_word(make_word(TLP, 1'b0, 1'b0, 16'h0000, d, 2'b11, LINK_MAGIC ^ 8'h80));
                send_word(make_word(CFG, 1'b1, 1'b0, 16'h8000, d, 2'b00, LINK_MAGIC));
            end
        end
        wait_drain();

        for (int i = 0; i < 8; i++) begin
            send_word(make_word(TLP, 1'b0, 1'b0, 16'h0000, 32'h5100_0000 + 32'(i),
                                {i % 4 == 0, i % 4 == 3}, LINK_MAGIC));
            queue_core_beat(32'h7100_0000 + 32'(i), i % 4 == 0, i % 4 == 3);
        end
        wait_drain();

        write_reg(16'h8004, 16'hffff, 16'd5);      // Count first
        write_reg(16'h8002, 16'h0002, 16'h0002);   // Then enable bit 17
        wait_drain();
        read_reg(16'h8004);
        write_reg(16'h8002, 16'h0002, 16'h0000);
        wait_drain();

        bp_en = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            r = $random(seed);
            d = $random(seed);
            case (r[1:0])
                2'd0:    send_loop(d, r[5:4]);
                2'd1:    read_reg(16'h8008 + {13'h0000, r[3:2], 1'b0});
                2'd2:    queue_core_beat(d, r[4], r[5]);
                default: write_reg(16'h8008 + {13'h0000, r[3:2], 1'b0}, r[31:16], d[15:0]);
            endcase
        end
        wait_drain();
        bp_en = 1'b0;
        repeat (4) @(posedge clk);

        if (pending() == 0 && !o_host_valid && core_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_fail("Output streams still busy at the end of the run");
        end
    end

endmodule

// ==== sources.f ====
hdl/com_pkg.sv
hdl/ctl_pkg.sv
hdl/sync_fifo.sv
hdl/rx_router.sv
hdl/ctl_regfile.sv
hdl/tx_mux.sv
hdl/fifo_ctl_top.sv
tests/tb_fifo_ctl.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_fifo_ctl \
    -Mdir obj_dir -o tb_fifo_ctl > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_fifo_ctl > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
